// ==== rtl/board_pkg.sv ====
// register indices, status layout, request and board signal structs, version constant
package board_pkg;

    // --------------------
    // sizes
    // --------------------
    localparam int NUM_AXES   = 4;  // amplifier channels
    localparam int REG_ADDR_W = 6;  // byte address, 16 words

    localparam logic [31:0] BOARD_VERSION = 32'h4243_0107;  // returned by REG_VERSION

    // word index of each mapped register, byte address is index * 4
    typedef enum logic [3:0] {
        REG_STATUS  = 4'd0,
        REG_TIMEOUT = 4'd3,
        REG_VERSION = 4'd4,
        REG_TEMPSNS = 4'd5,
        REG_DIGIN   = 4'd10
    } reg_index_e;

    // --------------------
    // status word bits
    // --------------------
    // write side, mask/value pairs
    localparam int ST_EN_VAL_LSB  = 0;   // per-axis enable values 3:0
    localparam int ST_EN_MASK_LSB = 8;   // per-axis enable masks 11:8
    localparam int ST_RELAY_VAL   = 16;
    localparam int ST_RELAY_MASK  = 17;
    localparam int ST_PWR_VAL     = 18;
    localparam int ST_PWR_MASK    = 19;
    localparam int ST_ETH_VAL     = 22;
    localparam int ST_ETH_MASK    = 23;

    // one register access, single cycle
    typedef struct packed {
        logic        wr;     // write strobe
        logic        rd;     // read strobe
        logic [3:0]  idx;    // word index
        logic [31:0] wdata;  // always full word
    } reg_req_t;

    // everything the board feeds in
    typedef struct packed {
        logic [NUM_AXES-1:0] fault;               // amplifier fault, per axis
        logic                relay;               // safety relay feedback
        logic                mv_good;             // motor supply good
        logic [3:0]          board_id;            // rotary switch
        logic [15:0]         temp_sense;          // temperature sensor
        logic [NUM_AXES-1:0] home;
        logic [NUM_AXES-1:0] pos_limit;
        logic [NUM_AXES-1:0] neg_limit;
        logic                v_fault;             // supply fault
        logic [NUM_AXES-1:0] safety_amp_disable;  // external safety chain
    } board_sense_t;

    // everything driven back to the board
    typedef struct packed {
        logic [NUM_AXES-1:0] amp_disable;  // 1 = amplifier off
        logic                pwr_enable;   // motor power
        logic                relay_on;     // safety relay drive
        logic                eth_mode;     // network mode select
    } board_ctrl_t;

endpackage

// ==== rtl/axil_reg_port.sv ====
// AXI4-Lite slave producing single-cycle register requests, write has priority
`timescale 1ns/10ps

module axil_reg_port (
    input  logic                               sysclk,
    input  logic                               reset,     // sync, active low
    // write address / data
    input  logic [board_pkg::REG_ADDR_W-1:0]   awaddr,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic [31:0]                        wdata,
    input  logic [3:0]                         wstrb,
    input  logic                               wvalid,
    output logic                               wready,
    // write response
    output logic                               bvalid,
    input  logic                               bready,
    output logic [1:0]                         bresp,
    // read address / data
    input  logic [board_pkg::REG_ADDR_W-1:0]   araddr,
    input  logic                               arvalid,
    output logic                               arready,
    output logic                               rvalid,
    input  logic                               rready,
    output logic [31:0]                        rdata,
    output logic [1:0]                         rresp,
    // register side
    output board_pkg::reg_req_t                req,
    input  logic [31:0]                        reg_rdata
);
    import board_pkg::*;

    logic wr_go;  // write accepted this cycle
    logic rd_go;  // read accepted this cycle

    // --------------------
    // arbitration
    // --------------------
    assign wr_go = awvalid && wvalid && !bvalid;   // aw and w taken together
    assign rd_go = arvalid && !rvalid && !wr_go;   // writes win

    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = rd_go;

    // request to the register file, only valid for one cycle
    always_comb begin
        req.wr    = wr_go;
        req.rd    = rd_go;
        req.idx   = wr_go ? awaddr[REG_ADDR_W-1:2] : araddr[REG_ADDR_W-1:2];
        req.wdata = wdata;  // strobes ignored
    end

    // --------------------
    // responses
    // --------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_go)
                bvalid <= 1'b1;       // reg file updated on this edge
            else if (bready)
                bvalid <= 1'b0;

            if (rd_go)
                rvalid <= 1'b1;       // read data captured on this edge
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    assign bresp = 2'b00;      // always OKAY
    assign rresp = 2'b00;
    assign rdata = reg_rdata;  // held by reg file until next read

    // B must wait for the host
    a_bvalid_hold : assert property (@(posedge sysclk) disable iff (!reset)
        bvalid && !bready |=> bvalid);

    // reg file must not touch read data while R is stalled
    a_rdata_stable : assert property (@(posedge sysclk) disable iff (!reset)
        rvalid && !rready |=> rvalid && $stable(rdata));

    // partial strobes still land as a full word
    c_partial_strobe : cover property (@(posedge sysclk) disable iff (!reset)
        wr_go && wstrb != 4'hf);

endmodule

// ==== rtl/host_watchdog.sv ====
// host watchdog with tick prescaler and a counter cleared by any register write
`timescale 1ns/10ps

module host_watchdog #(
    parameter int TICK_LOG2 = 8  // cycles per tick = 2**TICK_LOG2
) (
    input  logic                sysclk,
    input  logic                reset,        // synchronous active low
    input  board_pkg::reg_req_t req,
    input  logic [15:0]         wdog_period,  // period in ticks where 0 turns it off
    output logic                wdog_trip
);

    logic [TICK_LOG2-1:0] pre_cnt;   // free-running prescaler
    logic                 tick;
    logic [15:0]          wdog_cnt;  // ticks since last write

    assign tick = &pre_cnt;

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            pre_cnt   <= '0;
            wdog_cnt  <= '0;
            wdog_trip <= 1'b0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
            if (req.wr) begin
                // host alive
                wdog_cnt  <= '0;
                wdog_trip <= 1'b0;
            end else if (tick && wdog_period != 16'd0) begin
                if (wdog_cnt < wdog_period)
                    wdog_cnt <= wdog_cnt + 1'b1;
                if (wdog_cnt >= wdog_period - 16'd1)
                    wdog_trip <= 1'b1;   // count reaches the period on this tick
            end
        end
    end

    // a write always wins over a trip on the same edge
    a_no_trip_on_write : assert property (@(posedge sysclk) disable iff (!reset)
        req.wr |=> !wdog_trip);

endmodule

// ==== rtl/mv_good_delay.sv ====
// motor voltage settling delay, tick prescaler and hold counter
`timescale 1ns/10ps

module mv_good_delay #(
    parameter int TICK_LOG2      = 8,     // cycles per tick = 2**TICK_LOG2
    parameter int MV_DELAY_TICKS = 7680   // settling time in ticks
) (
    input  logic sysclk,
    input  logic reset,    // sync, active low
    input  logic mv_good,
    output logic mv_hold   // keep amplifiers off
);

    localparam int CNT_W = $clog2(MV_DELAY_TICKS + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(MV_DELAY_TICKS);

    logic [TICK_LOG2-1:0] pre_cnt;     // free-running prescaler
    logic                 tick;
    logic [CNT_W-1:0]     settle_cnt;  // ticks since mv_good rose

    assign tick = &pre_cnt;

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            pre_cnt    <= '0;
            settle_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
            if (!mv_good)
                settle_cnt <= '0;                  // restart on any dropout
            else if (tick && settle_cnt < CNT_MAX)
                settle_cnt <= settle_cnt + 1'b1;   // saturates at the limit
        end
    end

    // held while supply is down or still settling
    assign mv_hold = !mv_good || (settle_cnt < CNT_MAX);

    a_cnt_limit : assert property (@(posedge sysclk) disable iff (!reset)
        settle_cnt <= CNT_MAX);

endmodule

// ==== rtl/board_regs.sv ====
// board register file, control state, read mux and amplifier disable logic
`timescale 1ns/10ps

module board_regs (
    input  logic                    sysclk,
    input  logic                    reset,        // sync, active low
    input  board_pkg::reg_req_t     req,
    input  board_pkg::board_sense_t sense,
    input  logic                    wdog_trip,    // from host watchdog
    input  logic                    mv_hold,      // from settling delay
    output logic [31:0]             reg_rdata,
    output logic [15:0]             wdog_period,
    output board_pkg::board_ctrl_t  ctrl
);
    import board_pkg::*;

    logic [NUM_AXES-1:0] amp_dis;       // host disable register, 1 = off
    logic [NUM_AXES-1:0] amp_dis_wr;    // after a status write
    logic [NUM_AXES-1:0] amp_dis_next;
    logic                pwr_enable;
    logic                relay_on;
    logic                eth_mode;
    logic                status_wr;
    logic [31:0]         status_word;
    logic [31:0]         digin_word;

    assign status_wr = req.wr && (req.idx == REG_STATUS);

    // --------------------
    // disable register
    // --------------------
    always_comb begin
        amp_dis_wr = amp_dis;
        if (status_wr) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                if (req.wdata[ST_EN_MASK_LSB + i])
                    amp_dis_wr[i] = !req.wdata[ST_EN_VAL_LSB + i];  // enable bit inverted
                amp_dis_wr[i] = amp_dis_wr[i] || !pwr_enable;  // no power, no enable
            end
        end
        // trip and safety are sticky, host must re-enable
        amp_dis_next = amp_dis_wr | {NUM_AXES{wdog_trip}} | sense.safety_amp_disable;
    end

    // --------------------
    // control state
    // --------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            amp_dis     <= '1;      // everything off
            pwr_enable  <= 1'b0;
            relay_on    <= 1'b0;
            eth_mode    <= 1'b0;
            wdog_period <= 16'd0;   // watchdog off
        end else begin
            amp_dis <= amp_dis_next;
            if (status_wr) begin
                if (req.wdata[ST_RELAY_MASK])
                    relay_on <= req.wdata[ST_RELAY_VAL];
                if (req.wdata[ST_PWR_MASK])
                    pwr_enable <= req.wdata[ST_PWR_VAL];
                if (req.wdata[ST_ETH_MASK])
                    eth_mode <= req.wdata[ST_ETH_VAL];
            end
            if (req.wr && req.idx == REG_TIMEOUT)
                wdog_period <= req.wdata[15:0];
        end
    end

    // --------------------
    // read side
    // --------------------
    assign status_word = {
        4'(NUM_AXES), sense.board_id,              // byte 3
        wdog_trip, eth_mode, 2'b00,                // timeout, mode
        sense.mv_good, pwr_enable, !sense.relay, relay_on,
        4'b0000, sense.fault,                      // byte 1
        sense.safety_amp_disable, ~amp_dis         // live safety, enables
    };

    assign digin_word = {
        sense.v_fault, 15'd0,
        sense.neg_limit, sense.pos_limit, sense.home, 4'd0
    };

    // captured on the read strobe, held for the R channel
    always_ff @(posedge sysclk) begin
        if (req.rd) begin
            case (req.idx)
                REG_STATUS:  reg_rdata <= status_word;
                REG_TIMEOUT: reg_rdata <= {16'd0, wdog_period};
                REG_VERSION: reg_rdata <= BOARD_VERSION;
                REG_TEMPSNS: reg_rdata <= {16'd0, sense.temp_sense};
                REG_DIGIN:   reg_rdata <= digin_word;
                default:     reg_rdata <= 32'd0;   // unmapped
            endcase
        end
    end

    // outputs
    always_comb begin
        ctrl.amp_disable = amp_dis | {NUM_AXES{mv_hold}};  // settling overrides
        ctrl.pwr_enable  = pwr_enable;
        ctrl.relay_on    = relay_on;
        ctrl.eth_mode    = eth_mode;
    end

    // a watchdog trip shuts every axis on the next edge
    a_trip_disables : assert property (@(posedge sysclk) disable iff (!reset)
        wdog_trip |=> &amp_dis);

endmodule

// ==== rtl/board_ctrl_top.sv ====
// board control top level, AXI4-Lite port, register file and both timers
`timescale 1ns/10ps

module board_ctrl_top #(
    parameter int TICK_LOG2      = 8,     // cycles per timer tick, log2
    parameter int MV_DELAY_TICKS = 7680   // motor voltage settling ticks
) (
    input  logic                             sysclk,
    input  logic                             reset,    // sync, active low
    input  logic [board_pkg::REG_ADDR_W-1:0] awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [31:0]                      wdata,
    input  logic [3:0]                       wstrb,
    input  logic                             wvalid,
    output logic                             wready,
    output logic                             bvalid,
    input  logic                             bready,
    output logic [1:0]                       bresp,
    input  logic [board_pkg::REG_ADDR_W-1:0] araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output logic                             rvalid,
    input  logic                             rready,
    output logic [31:0]                      rdata,
    output logic [1:0]                       rresp,
    input  board_pkg::board_sense_t          sense,
    output board_pkg::board_ctrl_t           ctrl
);
    import board_pkg::*;

    reg_req_t    req;          // bus port to reg file and watchdog
    logic [31:0] reg_rdata;
    logic [15:0] wdog_period;
    logic        wdog_trip;
    logic        mv_hold;

    axil_reg_port i_axil_reg_port (
        .sysclk(sysclk), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .req(req), .reg_rdata(reg_rdata)
    );

    host_watchdog #(.TICK_LOG2(TICK_LOG2)) i_host_watchdog (
        .sysclk(sysclk), .reset(reset), .req(req),
        .wdog_period(wdog_period), .wdog_trip(wdog_trip)
    );

    mv_good_delay #(.TICK_LOG2(TICK_LOG2), .MV_DELAY_TICKS(MV_DELAY_TICKS)) i_mv_good_delay (
        .sysclk(sysclk), .reset(reset), .mv_good(sense.mv_good), .mv_hold(mv_hold)
    );

    board_regs i_board_regs (
        .sysclk(sysclk), .reset(reset), .req(req), .sense(sense),
        .wdog_trip(wdog_trip), .mv_hold(mv_hold), .reg_rdata(reg_rdata),
        .wdog_period(wdog_period), .ctrl(ctrl)
    );

endmodule

// ==== tb/tb_board_ctrl.sv ====
// board control testbench with AXI tasks, stimulus table, checks and timeout guard
`timescale 1ns/10ps

module tb_board_ctrl;
    import board_pkg::*;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_WAIT} op_e;

    // one table row
    typedef struct packed {
        op_e         op;
        logic [3:0]  idx;       // word index
        logic [31:0] wdata;
        logic [7:0]  wait_cyc;  // idle cycles after the access
        logic [2:0]  stall;     // cycles with bready / rready low
        logic        mv_good;
        logic [3:0]  safety;    // safety_amp_disable
        logic [31:0] exp_read;  // control bits only with sense fields added per row
        logic [6:0]  exp_ctrl;  // {amp_disable, pwr_enable, relay_on, eth_mode}
    } row_t;

    localparam int NUM_ROWS = 28;
    localparam row_t ROWS [NUM_ROWS] = '{
        // reset defaults
        '{OP_RD,   REG_STATUS,  32'h0000_0000, 8'd0,  3'd0, 1'b0, 4'h0, 32'h0000_0000, 7'h78},
        '{OP_RD,   REG_VERSION, 32'h0000_0000, 8'd0,  3'd3, 1'b0, 4'h0, BOARD_VERSION, 7'h78},
        '{OP_RD,   4'd7,        32'h0000_0000, 8'd0,  3'd0, 1'b0, 4'h0, 32'h0000_0000, 7'h78},
        // masked status writes where enable with power off does nothing
        '{OP_WR,   REG_STATUS,  32'h0000_0f0f, 8'd0,  3'd2, 1'b0, 4'h0, 32'h0000_0000, 7'h78},
        '{OP_RD,   REG_STATUS,  32'h0000_0000, 8'd0,  3'd0, 1'b0, 4'h0, 32'h0000_0000, 7'h78},
        '{OP_WR,   REG_STATUS,  32'h00cf_0000, 8'd0,  3'd0, 1'b0, 4'h0, 32'h0000_0000, 7'h7f},
        '{OP_WR,   REG_STATUS,  32'h0000_000f, 8'd0,  3'd0, 1'b0, 4'h0, 32'h0000_0000, 7'h7f},
        '{OP_RD,   REG_STATUS,  32'h0000_0000, 8'd0,  3'd0, 1'b0, 4'h0, 32'h0045_0000, 7'h7f},
        '{OP_WR,   REG_STATUS,  32'h0000_0505, 8'd0,  3'd0, 1'b0, 4'h0, 32'h0000_0000, 7'h7f},
        '{OP_RD,   REG_STATUS,  32'h0000_0000, 8'd0,  3'd0, 1'b0, 4'h0, 32'h0045_0005, 7'h7f},
        // settling holds for 5 ticks and releases after 17+
        '{OP_WAIT, 4'd0,        32'h0000_0000, 8'd20, 3'd0, 1'b1, 4'h0, 32'h0000_0000, 7'h7f},
        '{OP_WAIT, 4'd0,        32'h0000_0000, 8'd80, 3'd0, 1'b1, 4'h0, 32'h0000_0000, 7'h57},
        // host watchdog with a period of 5 ticks
        '{OP_WR,   REG_TIMEOUT, 32'h0000_0005, 8'd0,  3'd0, 1'b1, 4'h0, 32'h0000_0000, 7'h57},
        '{OP_RD,   REG_TIMEOUT, 32'h0000_0000, 8'd0,  3'd0, 1'b1, 4'h0, 32'h0000_0005, 7'h57},
        '{OP_WAIT, 4'd0,        32'h0000_0000, 8'd40, 3'd0, 1'b1, 4'h0, 32'h0000_0000, 7'h7f},
        '{OP_RD,   REG_STATUS,  32'h0000_0000, 8'd0,  3'd2, 1'b1, 4'h0, 32'h00c5_0000, 7'h7f},
        '{OP_RD,   REG_STATUS,  32'h0000_0000, 8'd0,  3'd0, 1'b1, 4'h0, 32'h00c5_0000, 7'h7f},
        '{OP_WR,   REG_TIMEOUT, 32'h0000_0000, 8'd0,  3'd0, 1'b1, 4'h0, 32'h0000_0000, 7'h7f},
        '{OP_RD,   REG_STATUS,  32'h0000_0000, 8'd0,  3'd0, 1'b1, 4'h0, 32'h0045_0000, 7'h7f},
        '{OP_WR,   REG_STATUS,  32'h0000_0f0f, 8'd0,  3'd0, 1'b1, 4'h0, 32'h0000_0000, 7'h07},
        '{OP_RD,   REG_STATUS,  32'h0000_0000, 8'd0,  3'd0, 1'b1, 4'h0, 32'h0045_000f, 7'h07},
        // safety pulse on axis 2 stays latched after release
        '{OP_WAIT, 4'd0,        32'h0000_0000, 8'd3,  3'd0, 1'b1, 4'h4, 32'h0000_0000, 7'h27},
        '{OP_RD,   REG_STATUS,  32'h0000_0000, 8'd0,  3'd0, 1'b1, 4'h4, 32'h0045_000b, 7'h27},
        '{OP_WAIT, 4'd0,        32'h0000_0000, 8'd3,  3'd0, 1'b1, 4'h0, 32'h0000_0000, 7'h27},
        '{OP_RD,   REG_STATUS,  32'h0000_0000, 8'd0,  3'd0, 1'b1, 4'h0, 32'h0045_000b, 7'h27},
        // input registers
        '{OP_RD,   REG_TEMPSNS, 32'h0000_0000, 8'd0,  3'd1, 1'b1, 4'h0, 32'h0000_0000, 7'h27},
        '{OP_RD,   REG_DIGIN,   32'h0000_0000, 8'd0,  3'd2, 1'b1, 4'h0, 32'h0000_0000, 7'h27},
        '{OP_RD,   REG_DIGIN,   32'h0000_0000, 8'd0,  3'd0, 1'b1, 4'h0, 32'h0000_0000, 7'h27}
    };

    logic         sysclk;
    logic         reset;
    logic [5:0]   awaddr, araddr;
    logic [31:0]  wdata, rdata;
    logic [3:0]   wstrb;
    logic         awvalid, awready, wvalid, wready, bvalid, bready;
    logic         arvalid, arready, rvalid, rready;
    logic [1:0]   bresp, rresp;
    board_sense_t sense;
    board_ctrl_t  ctrl;
    logic [31:0]  lcg_state = 32'h40b7_94dd;

    board_ctrl_top #(.TICK_LOG2(2), .MV_DELAY_TICKS(16)) i_board_ctrl_top (.*);

    initial begin
        sysclk = 1'b0;
        forever #4 sysclk = ~sysclk;  // 125 MHz
    end

    // --------------------
    // helpers
    // --------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // random board inputs with mv_good and safety taken from the row
    task automatic draw_sense(input row_t row, output board_sense_t s);
        logic [31:0] r1;
        logic [31:0] r2;
        lcg_state = lcg_next(lcg_state);
        r1 = lcg_state;
        lcg_state = lcg_next(lcg_state);
        r2 = lcg_state;
        s.temp_sense         = r1[31:16];
        s.fault              = r1[15:12];
        s.board_id           = r1[11:8];
        s.relay              = r1[7];
        s.v_fault            = r1[6];
        s.home               = r2[31:28];
        s.pos_limit          = r2[27:24];
        s.neg_limit          = r2[23:20];
        s.mv_good            = row.mv_good;
        s.safety_amp_disable = row.safety;
    endtask

    // sense-driven fields of a read word by register layout
    function automatic logic [31:0] sense_fields(input logic [3:0] idx, input board_sense_t s);
        case (idx)
            REG_STATUS:  return {4'd4, s.board_id, 4'b0000, s.mv_good, 1'b0, !s.relay, 1'b0,
                                 4'b0000, s.fault, s.safety_amp_disable, 4'b0000};
            REG_TEMPSNS: return {16'd0, s.temp_sense};
            REG_DIGIN:   return {s.v_fault, 15'd0, s.neg_limit, s.pos_limit, s.home, 4'd0};
            default:     return 32'd0;
        endcase
    endfunction

    // --------------------
    // AXI4-Lite master
    // --------------------
    task automatic write_reg(input logic [3:0] idx, input logic [31:0] data, input int stall);
        awaddr  <= {idx, 2'b00};
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= 4'h1;   // only byte 0 strobed yet the full word must land
        wvalid  <= 1'b1;
        bready  <= 1'b0;
        do @(posedge sysclk); while (!awready);  // aw and w taken together
        check("wready", 32'(wready), 32'd1);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        repeat (stall) begin
            @(posedge sysclk);
            check("bvalid", 32'(bvalid), 32'd1);  // held under back-pressure
        end
        bready <= 1'b1;
        do @(posedge sysclk); while (!bvalid);
        check("bresp", 32'(bresp), 32'd0);
        bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] idx, input int stall, output logic [31:0] data);
        araddr  <= {idx, 2'b00};
        arvalid <= 1'b1;
        rready  <= 1'b0;
        do @(posedge sysclk); while (!arready);
        arvalid <= 1'b0;
        repeat (stall) begin
            @(posedge sysclk);
            check("rvalid", 32'(rvalid), 32'd1);
        end
        rready <= 1'b1;
        do @(posedge sysclk); while (!rvalid);
        data = rdata;
        check("rresp", 32'(rresp), 32'd0);
        rready <= 1'b0;
    endtask

    // --------------------
    // table runner
    // --------------------
    initial begin : stimulus
        row_t         row;
        board_sense_t sense_now;
        logic [31:0]  rd_val;
        reset   <= 1'b0;
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= 4'hf;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        sense   <= '0;
        repeat (2) @(posedge sysclk);
        reset <= 1'b1;
        @(posedge sysclk);
        for (int i = 0; i < NUM_ROWS; i++) begin
            row = ROWS[i];
            draw_sense(row, sense_now);
            sense <= sense_now;
            @(posedge sysclk);  // inputs settle before the access
            case (row.op)
                OP_WR:   write_reg(row.idx, row.wdata, int'(row.stall));
                OP_RD: begin
                    read_reg(row.idx, int'(row.stall), rd_val);
                    check($sformatf("rdata[row %0d]", i), rd_val,
                          row.exp_read | sense_fields(row.idx, sense_now));
                end
                default: ;
            endcase
            repeat (row.wait_cyc) @(posedge sysclk);
            check($sformatf("ctrl[row %0d]", i), 32'(ctrl), 32'(row.exp_ctrl));
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    // ends a hung run with a limit that follows the table length
    initial begin : timeout_guard
        int limit;
        limit = 10;  // reset and start-up
        for (int i = 0; i < NUM_ROWS; i++)
            limit += int'(ROWS[i].wait_cyc) + 50;
        repeat (limit) @(posedge sysclk);
        $display("run timed out after %0d cycles before the table was done", limit);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule

// ==== list.f ====
rtl/board_pkg.sv
rtl/axil_reg_port.sv
rtl/host_watchdog.sv
rtl/mv_good_delay.sv
rtl/board_regs.sv
rtl/board_ctrl_top.sv
tb/tb_board_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_board_ctrl
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
